/* hdl/program_rom.svh */
// instruction encoders and the fixed program image for the fetch unit
`ifndef PROGRAM_ROM_SVH
`define PROGRAM_ROM_SVH

function automatic logic [31:0] rv_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
endfunction

function automatic logic [31:0] rv_i(input opcode_e opc, input logic [11:0] imm,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] rv_s(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};  // sw only
endfunction

function automatic logic [31:0] rv_b(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
endfunction

function automatic logic [31:0] rv_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
endfunction

// x1 periph base, x8 dtcm word 3, loop starts at word 2
function automatic logic [31:0] rom_word(input logic [$clog2(ROM_DEPTH)-1:0] idx);
    case (idx)
        5'd0:    return {PERIPH_BASE[31:12], 5'd1, LUI};
        5'd1:    return rv_i(OP_IMM, 12'(DTCM_BASE + 32'd12), 5'd0, 3'b000, 5'd8);
        5'd2:    return rv_i(LOAD, 12'(SW_LO_ADDR - PERIPH_BASE), 5'd1, 3'b010, 5'd2); // a
        5'd3:    return rv_i(LOAD, 12'(SW_HI_ADDR - PERIPH_BASE), 5'd1, 3'b010, 5'd3); // b
        5'd4:    return rv_i(LOAD, 12'(KEY_ADDR - PERIPH_BASE), 5'd1, 3'b010, 5'd4);   // k
        5'd5:    return rv_r(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd5);     // a+b
        5'd6:    return rv_s(12'd0, 5'd5, 5'd8);                        // through dtcm
        5'd7:    return rv_i(LOAD, 12'd0, 5'd8, 3'b010, 5'd6);          // s
        5'd8:    return rv_r(7'b0000000, 5'd3, 5'd2, 3'b100, 5'd7);     // a^b
        5'd9:    return rv_s(12'(SEG_LO_ADDR - PERIPH_BASE), 5'd7, 5'd1);
        5'd10:   return rv_s(12'(SEG_HI_ADDR - PERIPH_BASE), 5'd4, 5'd1);
        5'd11:   return rv_b(13'(12), 5'd0, 5'd4, 3'b001);              // k != 0
        5'd12:   return rv_s(12'(LED_ADDR - PERIPH_BASE), 5'd6, 5'd1);
        5'd13:   return rv_j(21'(-44), 5'd0);
        5'd14:   return rv_r(7'b0100000, 5'd4, 5'd6, 3'b000, 5'd6);     // s-k
        5'd15:   return rv_s(12'(LED_ADDR - PERIPH_BASE), 5'd6, 5'd1);
        5'd16:   return rv_j(21'(-56), 5'd0);
        default: return '0;  // decodes as invalid
    endcase
endfunction

`endif

/* hdl/alioth_pkg.sv */
// shared widths, memory map, opcode and control enums, pipeline structs
package alioth_pkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ROM_DEPTH      = 32;  // program words
    localparam int DTCM_DEPTH     = 16;  // data words

    // memory map
    localparam logic [XLEN-1:0] DTCM_BASE   = 32'h0000_0000;
    localparam logic [XLEN-1:0] PERIPH_BASE = 32'h1000_0000;
    localparam logic [XLEN-1:0] SW_LO_ADDR  = 32'h1000_0000;  // read only
    localparam logic [XLEN-1:0] SW_HI_ADDR  = 32'h1000_0004;  // read only
    localparam logic [XLEN-1:0] KEY_ADDR    = 32'h1000_0008;  // read only
    localparam logic [XLEN-1:0] LED_ADDR    = 32'h1000_0010;  // write only
    localparam logic [XLEN-1:0] SEG_LO_ADDR = 32'h1000_0014;  // write only
    localparam logic [XLEN-1:0] SEG_HI_ADDR = 32'h1000_0018;  // low byte kept

    // rv32 major opcodes used by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        logic [XLEN-1:0]           pc;
        alu_op_e                   alu_op;
        br_op_e                    br_op;
        logic                      use_imm;  // operand b from imm
        logic [XLEN-1:0]           imm;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic                      reg_we;
        logic                      mem_re;
        logic                      mem_we;
    } dec_info_t;

    typedef struct packed {
        logic            re;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      we;
        logic [REG_ADDR_WIDTH-1:0] waddr;
        logic [XLEN-1:0]           wdata;
    } wb_t;

endpackage

/* hdl/ifu.sv */
// instruction fetch unit: pc register, program rom lookup, fetch register with flush
`timescale 1ns/100ps

module ifu import alioth_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            redirect_i,     // taken branch or jal in execute
    input  logic [XLEN-1:0] redirect_pc_i,
    output fetch_t          fetch_o
);

`include "program_rom.svh"

    logic [XLEN-1:0] pc_q;       // address of the next fetch
    logic            valid_q;
    logic [XLEN-1:0] inst_pc_q;
    logic [XLEN-1:0] inst_q;
    logic [XLEN-1:0] rom_data;

    // rom indexed by word address
    assign rom_data = rom_word(pc_q[$clog2(ROM_DEPTH)+1:2]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else if (redirect_i) begin
            pc_q    <= redirect_pc_i;
            valid_q <= 1'b0;  // kill the word behind the branch
        end else begin
            pc_q    <= pc_q + 32'd4;
            valid_q <= 1'b1;
        end
    end

    // instruction word and its pc
    always_ff @(posedge clk) begin
        inst_pc_q <= pc_q;
        inst_q    <= rom_data;
    end

    assign fetch_o.valid = valid_q;
    assign fetch_o.pc    = inst_pc_q;
    assign fetch_o.inst  = inst_q;

endmodule

/* hdl/idu.sv */
// instruction decoder: opcode and funct decode, immediate forming, register indices
`timescale 1ns/100ps

module idu import alioth_pkg::*; (
    input  fetch_t                    fetch_i,
    output dec_info_t                 dec_o,
    output logic [REG_ADDR_WIDTH-1:0] rs1_o,
    output logic [REG_ADDR_WIDTH-1:0] rs2_o
);

    logic [XLEN-1:0] inst;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic            legal;

    assign inst   = fetch_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec_o        = '0;
        dec_o.pc     = fetch_i.pc;
        dec_o.rs1    = inst[19:15];
        dec_o.rs2    = inst[24:20];
        dec_o.rd     = inst[11:7];
        dec_o.alu_op = ALU_ADD;
        dec_o.br_op  = BR_NONE;
        legal        = 1'b1;
        case (opcode)
            OP: begin
                dec_o.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
                    default:              legal = 1'b0;
                endcase
            end
            OP_IMM: begin  // addi only
                legal         = (funct3 == 3'b000);
                dec_o.reg_we  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_i;
            end
            LOAD: begin  // lw only
                legal        = (funct3 == 3'b010);
                dec_o.reg_we = 1'b1;
                dec_o.mem_re = 1'b1;
                dec_o.imm    = imm_i;
            end
            STORE: begin  // sw only
                legal        = (funct3 == 3'b010);
                dec_o.mem_we = 1'b1;
                dec_o.imm    = imm_s;
            end
            BRANCH: begin
                dec_o.imm = imm_b;
                case (funct3)
                    3'b000:  dec_o.br_op = BR_EQ;
                    3'b001:  dec_o.br_op = BR_NE;
                    default: legal = 1'b0;
                endcase
            end
            JAL: begin
                dec_o.br_op  = BR_JAL;
                dec_o.reg_we = 1'b1;  // link pc+4
                dec_o.imm    = imm_j;
            end
            LUI: begin
                dec_o.alu_op  = ALU_PASS_B;
                dec_o.reg_we  = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
            end
            default: legal = 1'b0;
        endcase
        dec_o.valid = fetch_i.valid & legal;  // exu gates all side effects on this
    end

    assign rs1_o = dec_o.rs1;
    assign rs2_o = dec_o.rs2;

endmodule

/* hdl/gpr.sv */
// general purpose register file: 31 writable registers, two read ports, x0 tied to zero
`timescale 1ns/100ps

module gpr import alioth_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  wb_t                       wb_i,
    input  logic [REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [XLEN-1:0]           rdata1_o,
    output logic [XLEN-1:0]           rdata2_o
);

    logic [XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.waddr != '0)) begin  // x0 writes dropped
            regs_q[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // async read, same-cycle use by exu
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

/* hdl/exu.sv */
// execute unit: alu, branch and jump decision, load/store address, writeback select
`timescale 1ns/100ps

module exu import alioth_pkg::*; (
    input  dec_info_t       dec_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic [XLEN-1:0] mem_rdata_i,
    output mem_req_t        mem_req_o,
    output wb_t             wb_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] agu_addr;
    logic [XLEN-1:0] pc_plus4;
    logic            rs_equal;
    logic            br_taken;
    logic [XLEN-1:0] wb_data;

    assign op_b = dec_i.use_imm ? dec_i.imm : rs2_data_i;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = rs1_data_i + op_b;
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // branch unit
    assign rs_equal = (rs1_data_i == rs2_data_i);

    always_comb begin
        case (dec_i.br_op)
            BR_EQ:   br_taken = rs_equal;
            BR_NE:   br_taken = !rs_equal;
            BR_JAL:  br_taken = 1'b1;
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect_o    = dec_i.valid & br_taken;
    assign redirect_pc_o = dec_i.pc + dec_i.imm;  // pc relative for both b and j
    assign pc_plus4      = dec_i.pc + 32'd4;

    // agu for word loads and stores
    assign agu_addr = rs1_data_i + dec_i.imm;

    assign mem_req_o.re    = dec_i.valid & dec_i.mem_re;
    assign mem_req_o.we    = dec_i.valid & dec_i.mem_we;
    assign mem_req_o.addr  = agu_addr;
    assign mem_req_o.wdata = rs2_data_i;

    // writeback commits at the next edge
    always_comb begin
        if (dec_i.mem_re) begin
            wb_data = mem_rdata_i;
        end else if (dec_i.br_op == BR_JAL) begin
            wb_data = pc_plus4;  // link
        end else begin
            wb_data = alu_res;
        end
    end

    assign wb_o.we    = dec_i.valid & dec_i.reg_we;
    assign wb_o.waddr = dec_i.rd;
    assign wb_o.wdata = wb_data;

endmodule

/* hdl/mems.sv */
// data tcm, peripheral input and output registers, address decode and read select
`timescale 1ns/100ps

module mems import alioth_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  mem_req_t        mem_req_i,
    input  logic [63:0]     virtual_sw_input_i,
    input  logic [7:0]      virtual_key_input_i,
    output logic [XLEN-1:0] mem_rdata_o,
    output logic [39:0]     virtual_seg_output_o,
    output logic [31:0]     virtual_led_output_o
);

    logic [63:0]                   sw_q;
    logic [7:0]                    key_q;
    logic [31:0]                   led_q;
    logic [39:0]                   seg_q;
    logic [XLEN-1:0]               dtcm_mem [DTCM_DEPTH];
    logic [$clog2(DTCM_DEPTH)-1:0] dtcm_idx;
    logic                          dtcm_sel;

    assign dtcm_idx = mem_req_i.addr[$clog2(DTCM_DEPTH)+1:2];
    assign dtcm_sel = (mem_req_i.addr[XLEN-1:$clog2(DTCM_DEPTH)+2]
                       == DTCM_BASE[XLEN-1:$clog2(DTCM_DEPTH)+2]);

    always_ff @(posedge clk) begin
        if (mem_req_i.we && dtcm_sel) begin
            dtcm_mem[dtcm_idx] <= mem_req_i.wdata;
        end
    end

    // board pins registered in both directions
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sw_q  <= '0;
            key_q <= '0;
            led_q <= '0;
            seg_q <= '0;
        end else begin
            sw_q  <= virtual_sw_input_i;
            key_q <= virtual_key_input_i;
            if (mem_req_i.we) begin
                case (mem_req_i.addr)
                    LED_ADDR:    led_q         <= mem_req_i.wdata;
                    SEG_LO_ADDR: seg_q[31:0]   <= mem_req_i.wdata;
                    SEG_HI_ADDR: seg_q[39:32]  <= mem_req_i.wdata[7:0];  // upper digits
                    default:     ;  // unmapped, dropped
                endcase
            end
        end
    end

    // async read, unmapped and write-only addresses return zero
    always_comb begin
        mem_rdata_o = '0;
        if (mem_req_i.re) begin
            if (dtcm_sel) begin
                mem_rdata_o = dtcm_mem[dtcm_idx];
            end else begin
                case (mem_req_i.addr)
                    SW_LO_ADDR: mem_rdata_o = sw_q[31:0];
                    SW_HI_ADDR: mem_rdata_o = sw_q[63:32];
                    KEY_ADDR:   mem_rdata_o = {24'b0, key_q};
                    default:    mem_rdata_o = '0;
                endcase
            end
        end
    end

    assign virtual_led_output_o = led_q;
    assign virtual_seg_output_o = seg_q;

endmodule

/* hdl/cpu_top.sv */
// core top level: fetch, decode, register file, execute and memory blocks
`timescale 1ns/100ps

module cpu_top import alioth_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [63:0] virtual_sw_input_i,   // switch bank
    input  logic [7:0]  virtual_key_input_i,  // push keys
    output logic [39:0] virtual_seg_output_o, // seven segment digits
    output logic [31:0] virtual_led_output_o
);

    // fetch to decode
    fetch_t fetch;

    // decode to gpr and exu
    dec_info_t                 dec_info;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;

    // execute outputs
    mem_req_t        mem_req;
    logic [XLEN-1:0] mem_rdata;
    wb_t             wb;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;

    ifu u_ifu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .fetch_o       (fetch)
    );

    idu u_idu (
        .fetch_i (fetch),
        .dec_o   (dec_info),
        .rs1_o   (rs1_addr),
        .rs2_o   (rs2_addr)
    );

    gpr u_gpr (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    exu u_exu (
        .dec_i         (dec_info),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .mem_rdata_i   (mem_rdata),
        .mem_req_o     (mem_req),
        .wb_o          (wb),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    mems u_mems (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .mem_req_i            (mem_req),
        .virtual_sw_input_i   (virtual_sw_input_i),
        .virtual_key_input_i  (virtual_key_input_i),
        .mem_rdata_o          (mem_rdata),
        .virtual_seg_output_o (virtual_seg_output_o),
        .virtual_led_output_o (virtual_led_output_o)
    );

endmodule

/* dv/tb_model.svh */
// xorshift generator and expected led and segment values of the fixed program
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// led shows the sum of both switch words, minus the key byte when a key is held
function automatic logic [31:0] expected_led(input logic [31:0] sw_lo,
                                             input logic [31:0] sw_hi,
                                             input logic [7:0]  key);
    logic [31:0] sum;
    sum = sw_lo + sw_hi;  // wraps modulo 2^32
    if (key == 8'd0) begin
        return sum;
    end
    return sum - {24'b0, key};
endfunction

// upper digits take the key byte, lower word the xor of the switch words
function automatic logic [39:0] expected_seg(input logic [31:0] sw_lo,
                                             input logic [31:0] sw_hi,
                                             input logic [7:0]  key);
    return {key, sw_lo ^ sw_hi};
endfunction

`endif

/* dv/tb_cpu_top.sv */
// testbench for cpu_top: clock, reset, random switch and key trials, checks, watchdog
`timescale 1ns/100ps

module tb_cpu_top;

`include "tb_model.svh"

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TRIALS      = 60;
    localparam int HOLD_CYCLES     = 64;  // worst case settle after an input change
    localparam int WATCHDOG_CYCLES = NUM_TRIALS * HOLD_CYCLES * 2 + 100;

    logic        clk;
    logic        rst_n_i;
    logic [63:0] virtual_sw_input_i;
    logic [7:0]  virtual_key_input_i;
    logic [39:0] virtual_seg_output_o;
    logic [31:0] virtual_led_output_o;

    logic [31:0] rng_state;
    int          checks;
    int          led_errors;
    int          seg_errors;

    cpu_top i_dut (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .virtual_sw_input_i   (virtual_sw_input_i),
        .virtual_key_input_i  (virtual_key_input_i),
        .virtual_seg_output_o (virtual_seg_output_o),
        .virtual_led_output_o (virtual_led_output_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ends a stuck run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // random words, with corner sums in the first trials and k zero every fourth trial
    task automatic pick_inputs(input int trial, output logic [31:0] a,
                               output logic [31:0] b, output logic [7:0] k);
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
        rng_state = xorshift32(rng_state);
        k = rng_state[7:0];
        case (trial)
            1, 3: begin
                a = 32'hffff_ffff;
                b = 32'hffff_ffff;
            end
            2: begin
                a = 32'hffff_fff0;  // sum overflows
                b = 32'h0000_0020;
            end
            default: ;
        endcase
        if (trial % 4 == 3) begin
            k = 8'd0;
        end else if (k == 8'd0) begin
            k = 8'd1;
        end
    endtask

    task automatic check_outputs(input int trial, input logic [31:0] exp_led,
                                 input logic [39:0] exp_seg);
        checks++;
        if (virtual_led_output_o !== exp_led) begin
            led_errors++;
            $display("Error at %0t: trial %0d LED expected %h, got %h",
                     $time, trial, exp_led, virtual_led_output_o);
        end
        if (virtual_seg_output_o !== exp_seg) begin
            seg_errors++;
            $display("Error at %0t: trial %0d SEG expected %h, got %h",
                     $time, trial, exp_seg, virtual_seg_output_o);
        end
    endtask

    initial begin
        logic [31:0] sw_lo;
        logic [31:0] sw_hi;
        logic [7:0]  key;
        rng_state           = 32'd97073;
        checks              = 0;
        led_errors          = 0;
        seg_errors          = 0;
        rst_n_i             = 1'b0;
        virtual_sw_input_i  = '0;
        virtual_key_input_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_outputs(0, 32'd0, 40'd0);  // trial 0 is the idle state after reset
        for (int trial = 1; trial <= NUM_TRIALS; trial++) begin
            pick_inputs(trial, sw_lo, sw_hi, key);
            @(posedge clk);
            virtual_sw_input_i  <= {sw_hi, sw_lo};
            virtual_key_input_i <= key;
            repeat (HOLD_CYCLES) @(posedge clk);
            @(negedge clk);  // outputs settled, away from the driving edge
            check_outputs(trial, expected_led(sw_lo, sw_hi, key),
                          expected_seg(sw_lo, sw_hi, key));
        end
        $display("Summary: %0d checks, %0d LED errors, %0d SEG errors",
                 checks, led_errors, seg_errors);
        if (led_errors + seg_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* cpu_top.f */
+incdir+hdl
+incdir+dv
hdl/alioth_pkg.sv
hdl/ifu.sv
hdl/idu.sv
hdl/gpr.sv
hdl/exu.sv
hdl/mems.sv
hdl/cpu_top.sv
dv/tb_cpu_top.sv
